// ==== common/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Cache geometry
`define CACHE_SIZE_BYTES 2048
`define BLOCK_SIZE_BYTES 32
`define CACHE_ASSOC      4

`define ADDR_WIDTH       32
`define WORD_WIDTH       32

`define WORDS_PER_BLOCK  (`BLOCK_SIZE_BYTES * 8 / `WORD_WIDTH)
`define NUM_SETS         (`CACHE_SIZE_BYTES / (`BLOCK_SIZE_BYTES * `CACHE_ASSOC))

// Field widths of a byte address
`define SET_IDX_BITS     4
`define BLOCK_OFF_BITS   5
`define TAG_BITS         (`ADDR_WIDTH - `SET_IDX_BITS - `BLOCK_OFF_BITS)
`define WAY_IDX_BITS     2
`define WORD_IDX_BITS    3

`endif

// ==== common/cache_pkg.sv ====
package cache_pkg;

`include "cache_defines.svh"

    typedef logic [`ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`WORD_WIDTH-1:0]    word_t;
    // All zero means a load
    typedef logic [`WORD_WIDTH/8-1:0]  byte_en_t;
    typedef logic [`TAG_BITS-1:0]      tag_t;
    typedef logic [`SET_IDX_BITS-1:0]  set_idx_t;
    // Also an LRU age where 0 is most recent
    typedef logic [`WAY_IDX_BITS-1:0]  way_idx_t;
    typedef logic [`WORD_IDX_BITS-1:0] word_idx_t;

    typedef logic [`WORDS_PER_BLOCK-1:0][`WORD_WIDTH-1:0] block_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_state_t;

    typedef struct packed {
        logic     valid;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } core_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t rdata;
    } core_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  writeback;
        addr_t victim_addr;
        addr_t fill_addr;
    } miss_cmd_t;

endpackage

// ==== verilog/core_port.sv ====
`timescale 1ns/1ps

module core_port import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  core_req_t core_req,
    input  logic      busy,
    output core_req_t pend,
    input  core_rsp_t rsp_next,
    output core_rsp_t core_rsp
);

    logic     accept;
    logic     pend_valid;
    addr_t    pend_addr;
    word_t    pend_wdata;
    byte_en_t pend_byte_en;
    logic     rsp_valid;
    addr_t    rsp_addr;
    word_t    rsp_rdata;

    // Requests seen while busy are dropped
    assign accept = core_req.valid && !busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pend_valid <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            pend_valid <= accept;
            rsp_valid  <= rsp_next.valid;
        end
    end

    // Request fields stay put until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_addr    <= core_req.addr;
            pend_wdata   <= core_req.wdata;
            pend_byte_en <= core_req.byte_en;
        end
        rsp_addr  <= rsp_next.addr;
        rsp_rdata <= rsp_next.rdata;
    end

    assign pend     = '{valid: pend_valid, addr: pend_addr, wdata: pend_wdata,
                        byte_en: pend_byte_en};
    assign core_rsp = '{valid: rsp_valid, addr: rsp_addr, rdata: rsp_rdata};

endmodule

// ==== cache_ctrl/cache_store.sv ====
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_store import cache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  set_idx_t    set_idx,
    input  tag_t        lookup_tag,
    output logic        hit,
    output way_idx_t    hit_way,
    output block_t      hit_data,
    output way_idx_t    victim_way,
    output line_state_t victim_state,
    output block_t      victim_data,
    input  logic        wr_en,
    input  way_idx_t    wr_way,
    input  line_state_t wr_state,
    input  block_t      wr_data,
    input  logic        touch,
    input  way_idx_t    touch_way
);

    line_state_t state_q [`NUM_SETS][`CACHE_ASSOC];
    block_t      data_q  [`NUM_SETS][`CACHE_ASSOC];
    way_idx_t    age_q   [`NUM_SETS][`CACHE_ASSOC];

    way_idx_t    touch_age;

    // Tag compare over all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_ASSOC; w++) begin
            if (state_q[set_idx][w].valid && state_q[set_idx][w].tag == lookup_tag) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    // Victim is the least recent way
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < `CACHE_ASSOC; w++) begin
            if (age_q[set_idx][w] == way_idx_t'(`CACHE_ASSOC - 1)) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    assign hit_data     = data_q[set_idx][hit_way];
    assign victim_state = state_q[set_idx][victim_way];
    assign victim_data  = data_q[set_idx][victim_way];
    assign touch_age    = age_q[set_idx][touch_way];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `NUM_SETS; s++) begin
                for (int w = 0; w < `CACHE_ASSOC; w++) begin
                    state_q[s][w] <= '0;
                    age_q[s][w]   <= way_idx_t'(w);
                end
            end
        end else begin
            if (wr_en) begin
                state_q[set_idx][wr_way] <= wr_state;
            end
            if (touch) begin
                for (int w = 0; w < `CACHE_ASSOC; w++) begin
                    if (way_idx_t'(w) == touch_way) begin
                        age_q[set_idx][w] <= '0;
                    end else if (age_q[set_idx][w] < touch_age) begin
                        age_q[set_idx][w] <= age_q[set_idx][w] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q[set_idx][wr_way] <= wr_data;
        end
    end

endmodule

// ==== cache_ctrl/cache_ctrl.sv ====
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  core_req_t   pend,
    output logic        busy,
    output core_rsp_t   rsp_next,
    output set_idx_t    set_idx,
    output tag_t        lookup_tag,
    input  logic        hit,
    input  way_idx_t    hit_way,
    input  way_idx_t    victim_way,
    input  line_state_t victim_state,
    input  block_t      victim_data,
    input  block_t      hit_data,
    output logic        wr_en,
    output way_idx_t    wr_way,
    output line_state_t wr_state,
    output block_t      wr_data,
    output logic        touch,
    output way_idx_t    touch_way,
    output miss_cmd_t   miss_cmd,
    output block_t      evict_data,
    input  logic        fill_done,
    input  block_t      fill_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_miss_wait,
        st_fill_install
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t phase;
    word_idx_t   word_idx;
    logic        is_store;
    block_t      merged_hit;
    block_t      merged_fill;

    function automatic block_t merge_word(block_t blk, word_idx_t idx, word_t wdata,
                                          byte_en_t be);
        block_t res;
        res = blk;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (be[b]) begin
                res[idx][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign set_idx    = pend.addr[`BLOCK_OFF_BITS +: `SET_IDX_BITS];
    assign lookup_tag = pend.addr[`ADDR_WIDTH-1 -: `TAG_BITS];
    assign word_idx   = pend.addr[`BLOCK_OFF_BITS-1 -: `WORD_IDX_BITS];
    assign is_store   = |pend.byte_en;

    assign merged_hit  = merge_word(hit_data, word_idx, pend.wdata, pend.byte_en);
    assign merged_fill = merge_word(fill_data, word_idx, pend.wdata, pend.byte_en);

    assign evict_data = victim_data;
    assign busy       = (state != st_idle) || pend.valid;

    // Lookup and install run in the cycle their strobe arrives
    always_comb begin
        phase = state;
        if (state == st_idle && pend.valid) begin
            phase = st_lookup;
        end
        if (state == st_miss_wait && fill_done) begin
            phase = st_fill_install;
        end
    end

    always_comb begin
        next_state = state;
        wr_en      = 1'b0;
        wr_way     = hit_way;
        wr_state   = '{valid: 1'b1, dirty: 1'b1, tag: lookup_tag};
        wr_data    = merged_hit;
        touch      = 1'b0;
        touch_way  = hit_way;
        rsp_next   = '{valid: 1'b0, addr: pend.addr, rdata: merged_hit[word_idx]};
        miss_cmd   = '{valid: 1'b0,
                       writeback: victim_state.valid && victim_state.dirty,
                       victim_addr: {victim_state.tag, set_idx, {`BLOCK_OFF_BITS{1'b0}}},
                       fill_addr: {lookup_tag, set_idx, {`BLOCK_OFF_BITS{1'b0}}}};

        case (phase)
            st_lookup: begin
                if (hit) begin
                    // A load hit only refreshes the age
                    wr_en          = is_store;
                    touch          = 1'b1;
                    rsp_next.valid = 1'b1;
                end else begin
                    miss_cmd.valid = 1'b1;
                    next_state     = st_miss_wait;
                end
            end
            st_fill_install: begin
                wr_en          = 1'b1;
                wr_way         = victim_way;
                wr_state.dirty = is_store;
                wr_data        = merged_fill;
                touch          = 1'b1;
                touch_way      = victim_way;
                rsp_next.valid = 1'b1;
                rsp_next.rdata = merged_fill[word_idx];
                next_state     = st_idle;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== verilog/mem_sequencer.sv ====
`timescale 1ns/1ps

`include "cache_defines.svh"

module mem_sequencer import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  miss_cmd_t miss_cmd,
    input  block_t    evict_data,
    output mem_req_t  mem_req,
    input  mem_rsp_t  mem_rsp,
    output logic      fill_done,
    output block_t    fill_data
);

    typedef enum logic [1:0] {
        seq_idle,
        seq_write,
        seq_read
    } seq_phase_t;

    seq_phase_t phase;
    word_idx_t  cnt;
    logic       start;
    logic       wr_ack;
    logic       rd_ack;
    logic       last;
    logic       req_valid;
    logic       req_write;
    addr_t      req_addr;
    word_t      req_wdata;
    addr_t      fill_base;
    block_t     buffer;

    assign start  = (phase == seq_idle) && miss_cmd.valid;
    assign wr_ack = (phase == seq_write) && mem_rsp.valid;
    assign rd_ack = (phase == seq_read) && mem_rsp.valid;
    assign last   = cnt == word_idx_t'(`WORDS_PER_BLOCK - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= seq_idle;
            cnt       <= '0;
            req_valid <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            req_valid <= start || wr_ack || (rd_ack && !last);
            fill_done <= rd_ack && last;
            if (start) begin
                phase <= miss_cmd.writeback ? seq_write : seq_read;
                cnt   <= '0;
            end else if (wr_ack || rd_ack) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    phase <= wr_ack ? seq_read : seq_idle;
                end
            end
        end
    end

    // The buffer holds the victim first, then collects the refill
    always_ff @(posedge clk) begin
        if (start) begin
            buffer    <= evict_data;
            fill_base <= miss_cmd.fill_addr;
            req_write <= miss_cmd.writeback;
            req_addr  <= miss_cmd.writeback ? miss_cmd.victim_addr : miss_cmd.fill_addr;
            req_wdata <= evict_data[0];
        end else if (wr_ack) begin
            req_write <= !last;
            req_addr  <= last ? fill_base : req_addr + 4;
            req_wdata <= buffer[cnt + 1'b1];
        end else if (rd_ack) begin
            buffer[cnt] <= mem_rsp.rdata;
            req_addr    <= req_addr + 4;
        end
    end

    assign mem_req   = '{valid: req_valid, write: req_write, addr: req_addr, wdata: req_wdata};
    assign fill_data = buffer;

endmodule

// ==== verilog/assoc_cache.sv ====
`timescale 1ns/1ps

module assoc_cache import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  core_req_t core_req,
    output core_rsp_t core_rsp,
    output logic      busy,
    output mem_req_t  mem_req,
    input  mem_rsp_t  mem_rsp
);

    core_req_t   pend;
    core_rsp_t   rsp_next;
    set_idx_t    set_idx;
    tag_t        lookup_tag;
    logic        hit;
    way_idx_t    hit_way;
    way_idx_t    victim_way;
    line_state_t victim_state;
    block_t      victim_data;
    block_t      hit_data;
    logic        wr_en;
    way_idx_t    wr_way;
    line_state_t wr_state;
    block_t      wr_data;
    logic        touch;
    way_idx_t    touch_way;
    miss_cmd_t   miss_cmd;
    block_t      evict_data;
    logic        fill_done;
    block_t      fill_data;

    core_port core_port_i (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .busy     (busy),
        .pend     (pend),
        .rsp_next (rsp_next),
        .core_rsp (core_rsp)
    );

    cache_ctrl cache_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .pend         (pend),
        .busy         (busy),
        .rsp_next     (rsp_next),
        .set_idx      (set_idx),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_state (victim_state),
        .victim_data  (victim_data),
        .hit_data     (hit_data),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_state     (wr_state),
        .wr_data      (wr_data),
        .touch        (touch),
        .touch_way    (touch_way),
        .miss_cmd     (miss_cmd),
        .evict_data   (evict_data),
        .fill_done    (fill_done),
        .fill_data    (fill_data)
    );

    cache_store cache_store_i (
        .clk          (clk),
        .reset        (reset),
        .set_idx      (set_idx),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_way   (victim_way),
        .victim_state (victim_state),
        .victim_data  (victim_data),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_state     (wr_state),
        .wr_data      (wr_data),
        .touch        (touch),
        .touch_way    (touch_way)
    );

    mem_sequencer mem_sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .miss_cmd   (miss_cmd),
        .evict_data (evict_data),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .fill_done  (fill_done),
        .fill_data  (fill_data)
    );

endmodule

// ==== testbench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model import cache_pkg::*; #(
    parameter int mem_words = 1024,
    parameter int log_depth = 4096
) (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    word_t       mem       [mem_words];
    addr_t       log_addr  [log_depth];
    logic        log_write [log_depth];
    word_t       log_wdata [log_depth];
    int          log_count;
    int          range_errors;
    int          idx;
    // Each response trails its request by three cycles
    logic  [1:0] stage_valid;
    word_t       stage_data [2];

    function automatic word_t initial_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        log_count    = 0;
        range_errors = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = initial_word(addr_t'(i * 4));
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_valid <= 2'b00;
            mem_rsp     <= '0;
        end else begin
            stage_valid   <= {stage_valid[0], mem_req.valid};
            stage_data[1] <= stage_data[0];
            mem_rsp       <= '{valid: stage_valid[1], rdata: stage_data[1]};
            if (mem_req.valid) begin
                idx = int'(mem_req.addr >> 2);
                if (mem_req.addr[1:0] != 2'b00 || idx >= mem_words || log_count >= log_depth) begin
                    range_errors++;
                    $display("Memory access to %h at %0t falls outside the model",
                             mem_req.addr, $time);
                end else begin
                    stage_data[0] <= mem[idx];
                    if (mem_req.write) begin
                        mem[idx] <= mem_req.wdata;
                    end
                    log_addr[log_count]  = mem_req.addr;
                    log_write[log_count] = mem_req.write;
                    log_wdata[log_count] = mem_req.wdata;
                    log_count++;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_assoc_cache.sv ====
`timescale 1ns/1ps

`include "cache_defines.svh"

module tb_assoc_cache import cache_pkg::*; ();

    localparam int directed_requests = 19;
    localparam int random_requests   = 120;
    localparam int num_requests      = directed_requests + random_requests;
    localparam int cycle_limit       = 40 * num_requests;
    localparam int mem_words         = 1024;

    logic        clk;
    logic        reset;
    core_req_t   core_req;
    core_rsp_t   core_rsp;
    logic        busy;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    logic [31:0] lfsr;
    int          cycles;
    int          error_count;
    int          check_count;
    int          sent_count;
    int          rsp_count;

    // Reference view of memory as the core sees it, and of the cache directory
    word_t       ref_mem   [mem_words];
    logic        ref_valid [`NUM_SETS][`CACHE_ASSOC];
    logic        ref_dirty [`NUM_SETS][`CACHE_ASSOC];
    tag_t        ref_tag   [`NUM_SETS][`CACHE_ASSOC];
    way_idx_t    ref_age   [`NUM_SETS][`CACHE_ASSOC];

    assoc_cache assoc_cache_i (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .busy     (busy),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    mem_model #(.mem_words(mem_words)) mem_model_i (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Checks %0d, errors %0d, requests %0d, responses %0d",
                     check_count, error_count, sent_count, rsp_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (core_rsp.valid === 1'b1) begin
            rsp_count++;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    function automatic word_t initial_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic addr_t make_addr(int tag, int set, int word);
        return addr_t'((tag << 9) | (set << 5) | (word << 2));
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t d, byte_en_t be);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic touch_ref(int s, int w);
        way_idx_t old;
        old = ref_age[s][w];
        for (int v = 0; v < `CACHE_ASSOC; v++) begin
            if (ref_age[s][v] < old) begin
                ref_age[s][v] = ref_age[s][v] + 1'b1;
            end
        end
        ref_age[s][w] = '0;
    endtask

    // One request with an optional second strobe while the cache is busy
    task automatic send_request(addr_t a, word_t d, byte_en_t be, logic inject);
        int    s, tag, way, wb, n_exp, log_base, lat, li;
        logic  hit;
        addr_t ea;
        word_t exp_word;
        s   = a[8:5];
        tag = a[31:9];
        hit = 1'b0;
        way = 0;
        for (int v = 0; v < `CACHE_ASSOC; v++) begin
            if (ref_valid[s][v] && ref_tag[s][v] == tag) begin
                hit = 1'b1;
                way = v;
            end
        end
        for (int v = 0; v < `CACHE_ASSOC; v++) begin
            if (!hit && ref_age[s][v] == 2'd3) begin
                way = v;
            end
        end
        wb       = !hit && ref_valid[s][way] && ref_dirty[s][way];
        n_exp    = hit ? 0 : (wb ? 16 : 8);
        log_base = mem_model_i.log_count;

        @(posedge clk);
        core_req <= '{valid: 1'b1, addr: a, wdata: d, byte_en: be};
        sent_count++;
        @(posedge clk);
        core_req <= '{valid: inject, addr: a ^ 32'h200, wdata: ~d, byte_en: 4'hf};
        @(negedge clk);
        if (inject) begin
            check_value("busy", busy, 1'b1);
        end
        @(posedge clk);
        core_req.valid <= 1'b0;
        lat = 2;
        @(negedge clk);
        while (core_rsp.valid !== 1'b1) begin
            @(negedge clk);
            lat++;
        end

        exp_word = merge_bytes(ref_mem[a[11:2]], d, be);
        check_value("core_rsp.addr", core_rsp.addr, a);
        check_value("core_rsp.rdata", core_rsp.rdata, exp_word);
        check_value("response latency", lat, hit ? 2 : 3 + 4 * n_exp);
        check_value("mem_req count", mem_model_i.log_count - log_base, n_exp);
        for (int i = 0; i < n_exp; i++) begin
            li = log_base + i;
            if (wb && i < 8) begin
                ea = make_addr(ref_tag[s][way], s, i);
                check_value("mem_req.write", mem_model_i.log_write[li], 1'b1);
                check_value("mem_req.wdata", mem_model_i.log_wdata[li], ref_mem[ea[11:2]]);
            end else begin
                ea = make_addr(tag, s, wb ? i - 8 : i);
                check_value("mem_req.write", mem_model_i.log_write[li], 1'b0);
            end
            check_value("mem_req.addr", mem_model_i.log_addr[li], ea);
        end

        ref_mem[a[11:2]] = exp_word;
        if (!hit) begin
            ref_valid[s][way] = 1'b1;
            ref_tag[s][way]   = tag_t'(tag);
            ref_dirty[s][way] = 1'b0;
        end
        ref_dirty[s][way] = ref_dirty[s][way] | (be != 4'h0);
        touch_ref(s, way);
    endtask

    initial begin
        int       tag_r, set_r, word_r;
        word_t    d;
        byte_en_t be;
        logic     inj;
        clk         = 1'b0;
        reset       = 1'b1;
        core_req    = '0;
        lfsr        = 32'd87415;
        cycles      = 0;
        error_count = 0;
        check_count = 0;
        sent_count  = 0;
        rsp_count   = 0;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = initial_word(addr_t'(i * 4));
        end
        for (int s = 0; s < `NUM_SETS; s++) begin
            for (int w = 0; w < `CACHE_ASSOC; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_age[s][w]   = way_idx_t'(w);
            end
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        check_value("core_rsp.valid", core_rsp.valid, 1'b0);
        check_value("mem_req.valid", mem_req.valid, 1'b0);

        // Cold miss, then a load hit and a store hit on the same line
        send_request(make_addr(0, 12, 3), '0, 4'h0, 1'b0);
        send_request(make_addr(0, 12, 6), '0, 4'h0, 1'b0);
        d = take_bits(32);
        send_request(make_addr(0, 12, 6), d, byte_en_t'(take_bits(4)) | 4'h1, 1'b0);

        // Fill set 13, refresh tag 0, so tag 4 should replace tag 1
        for (int t = 0; t < 4; t++) begin
            send_request(make_addr(t, 13, t), '0, 4'h0, 1'b0);
        end
        send_request(make_addr(0, 13, 1), '0, 4'h0, 1'b0);
        send_request(make_addr(4, 13, 2), '0, 4'h0, 1'b0);
        send_request(make_addr(1, 13, 0), '0, 4'h0, 1'b0);

        // Dirty victim first, then clean victims
        send_request(make_addr(0, 14, 5), take_bits(32), 4'hf, 1'b0);
        for (int t = 1; t < 6; t++) begin
            send_request(make_addr(t, 14, 0), '0, 4'h0, 1'b0);
        end
        send_request(make_addr(0, 14, 5), '0, 4'h0, 1'b0);

        // Store to tag 5 arrives while busy and must be lost
        send_request(make_addr(4, 14, 1), take_bits(32), 4'h0, 1'b1);
        send_request(make_addr(5, 14, 1), '0, 4'h0, 1'b0);

        for (int i = 0; i < random_requests; i++) begin
            tag_r  = take_bits(3);
            set_r  = take_bits(2);
            word_r = take_bits(3);
            d      = take_bits(32);
            be     = take_bits(1) ? byte_en_t'(take_bits(4)) : 4'h0;
            inj    = take_bits(3) == 0;
            send_request(make_addr(tag_r, set_r, word_r), d, be, inj);
        end

        repeat (4) @(negedge clk);
        check_value("core_rsp count", rsp_count, sent_count);
        check_value("memory range errors", mem_model_i.range_errors, 0);
        $display("Checks %0d, errors %0d, requests %0d, responses %0d",
                 check_count, error_count, sent_count, rsp_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== assoc_cache.f ====
+incdir+common
common/cache_pkg.sv
verilog/core_port.sv
cache_ctrl/cache_store.sv
cache_ctrl/cache_ctrl.sv
verilog/mem_sequencer.sv
verilog/assoc_cache.sv
testbench/mem_model.sv
testbench/tb_assoc_cache.sv
